// File: common/exu_pkg.sv
// ----------------------------------------
// Execute subsystem package
// Unit indices, micro-op encodings, result
// kinds and width constants
// ----------------------------------------
package exu_pkg;

    parameter int XLEN_DEF = 32;            // Default data width
    parameter int RD_W     = 5;             // Register address width
    parameter int UOP_W    = 5;             // Micro-op width
    parameter int KIND_W   = 2;             // Result kind width

    // One-hot functional unit select
    parameter int FU_W   = 3;
    parameter int FU_ALU = 0;
    parameter int FU_MUL = 1;
    parameter int FU_CFU = 2;

    typedef enum logic [UOP_W-1:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_AND  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9
    } alu_op_e;

    typedef enum logic [UOP_W-1:0] {
        MUL_MUL   = 5'd0,                   // Low half of product
        MUL_MULHU = 5'd1                    // High half, unsigned
    } mul_op_e;

    typedef enum logic [1:0] {CFU_COND = 2'd0, CFU_JAL = 2'd1, CFU_JALR = 2'd2} cfu_kind_e;

    // Condition codes follow the branch funct3 field
    typedef enum logic [2:0] {
        CND_BEQ  = 3'd0,
        CND_BNE  = 3'd1,
        CND_BLT  = 3'd4,
        CND_BGE  = 3'd5,
        CND_BLTU = 3'd6,
        CND_BGEU = 3'd7
    } cfu_cond_e;

    typedef struct packed {
        cfu_kind_e kind;                    // Branch, jal or jalr
        cfu_cond_e cond;                    // Only for conditional
    } cfu_fields_t;

    // Same micro-op word, ALU view or control-flow view
    typedef union packed {
        alu_op_e     alu;
        cfu_fields_t cfu;
    } uop_u;

    typedef enum logic [KIND_W-1:0] {
        RES_NONE     = 2'd0,                // Nothing to retire
        RES_WRITE    = 2'd1,                // Register file write
        RES_REDIRECT = 2'd2                 // Fetch redirect
    } res_kind_e;

endpackage

// File: execute/exu_alu.sv
// ----------------------------------------
// ALU
// Adder, logic ops, barrel shifter and
// signed/unsigned comparator
// ----------------------------------------
module exu_alu #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic            i_op_add,
    input  logic            i_op_sub,
    input  logic            i_op_xor,
    input  logic            i_op_or,
    input  logic            i_op_and,
    input  logic            i_op_shf,           // Any shift
    input  logic            i_op_shf_left,
    input  logic            i_op_shf_arith,
    input  logic            i_op_cmp,           // slt or sltu
    input  logic            i_op_unsigned,      // Unsigned compare
    input  logic [XLEN-1:0] i_lhs,
    input  logic [XLEN-1:0] i_rhs,
    output logic [XLEN-1:0] o_result,
    output logic [XLEN-1:0] o_add_result,
    output logic            o_lt,
    output logic            o_eq
);

    localparam int SH_W = $clog2(XLEN);

    logic [XLEN:0]          diff;               // Extra bit is the borrow
    logic [XLEN-1:0]        shf_in, shf_raw, shf_out;
    logic signed [XLEN:0]   shf_ext;

    assign o_add_result = i_lhs + i_rhs;
    assign diff         = {1'b0, i_lhs} - {1'b0, i_rhs};     // Shared by sub and compare
    assign o_eq         = diff[XLEN-1:0] == '0;

    // Signs differ means lhs sign decides
    assign o_lt = i_op_unsigned ? diff[XLEN] :
                  (i_lhs[XLEN-1] ^ i_rhs[XLEN-1]) ? i_lhs[XLEN-1] : diff[XLEN-1];

    // Left shift is a right shift of the reversed word
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shf_in[i] = i_op_shf_left ? i_lhs[XLEN-1-i] : i_lhs[i];
        end
    end

    assign shf_ext = $signed({i_op_shf_arith & i_lhs[XLEN-1], shf_in}) >>> i_rhs[SH_W-1:0];
    assign shf_raw = shf_ext[XLEN-1:0];

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shf_out[i] = i_op_shf_left ? shf_raw[XLEN-1-i] : shf_raw[i];
        end
    end

    assign o_result = {XLEN{i_op_add}} & o_add_result     |
                      {XLEN{i_op_sub}} & diff[XLEN-1:0]   |
                      {XLEN{i_op_xor}} & (i_lhs ^ i_rhs)  |
                      {XLEN{i_op_or }} & (i_lhs | i_rhs)  |
                      {XLEN{i_op_and}} & (i_lhs & i_rhs)  |
                      {XLEN{i_op_shf}} & shf_out          |
                      {{(XLEN-1){1'b0}}, i_op_cmp & o_lt};

endmodule

// File: execute/exu_muldiv.sv
// ----------------------------------------
// Iterative multiplier
// Radix-2 shift-add, one bit per cycle,
// low or high half of unsigned product
// ----------------------------------------
module exu_muldiv #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic            g_clk,
    input  logic            i_rst_n,
    input  logic            i_flush,            // Abort current product
    input  logic            i_valid,            // Multiply op presented
    input  logic            i_high,             // Return upper half
    input  logic            i_progress,         // Result consumed
    input  logic [XLEN-1:0] i_lhs,
    input  logic [XLEN-1:0] i_rhs,
    output logic            o_ready,
    output logic [XLEN-1:0] o_result
);

    localparam int CNT_W = $clog2(XLEN);

    logic [2*XLEN-1:0] acc, acc_cur;            // {partial sum, multiplier}
    logic [XLEN-1:0]   mcand, mcand_cur;
    logic [XLEN:0]     sum;                     // Upper half plus carry
    logic [CNT_W-1:0]  count;                   // Bits done, wraps at end
    logic              done;

    wire started = count != '0;
    wire step    = i_valid && !done;

    // First step works straight from the operands
    assign acc_cur   = started ? acc : {{XLEN{1'b0}}, i_rhs};
    assign mcand_cur = started ? mcand : i_lhs;
    assign sum       = {1'b0, acc_cur[2*XLEN-1:XLEN]} + (acc_cur[0] ? {1'b0, mcand_cur} : '0);

    always_ff @(posedge g_clk) begin
        if (!i_rst_n || i_flush || i_progress) begin
            count <= '0;
            done  <= 1'b0;
        end else if (step) begin
            count <= count + 1'b1;
            if (count == CNT_W'(XLEN - 1)) begin
                done <= 1'b1;                   // Last bit this edge
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (step) begin
            acc   <= {sum, acc_cur[XLEN-1:1]};  // Add then shift right
            mcand <= mcand_cur;
        end
    end

    assign o_ready  = done;
    assign o_result = i_high ? acc[2*XLEN-1:XLEN] : acc[XLEN-1:0];

endmodule

// File: execute/exu_execute.sv
// ----------------------------------------
// Execute stage
// Decodes unit and micro-op, runs ALU and
// multiplier, resolves branches
// ----------------------------------------
module exu_execute #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                         g_clk,
    input  logic                         i_rst_n,
    input  logic                         i_flush,        // Abort multiplier
    input  logic                         i_s2_valid,     // Dispatch has an op
    output logic                         o_s2_busy,      // Stall dispatch
    input  logic [exu_pkg::RD_W-1:0]     i_s2_rd,
    input  logic [exu_pkg::FU_W-1:0]     i_s2_fu,        // One-hot unit
    input  exu_pkg::uop_u                i_s2_uop,
    input  logic [XLEN-1:0]              i_s2_opr_a,
    input  logic [XLEN-1:0]              i_s2_opr_b,
    input  logic [XLEN-1:0]              i_s2_opr_c,     // Branch target
    output logic                         o_p_valid,      // To pipeline register
    input  logic                         i_p_busy,
    output logic [exu_pkg::RD_W-1:0]     o_p_rd,
    output exu_pkg::res_kind_e           o_p_kind,
    output logic [XLEN-1:0]              o_p_value       // Write data or target
);

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    wire fu_alu = i_s2_fu[exu_pkg::FU_ALU];
    wire fu_mul = i_s2_fu[exu_pkg::FU_MUL];
    wire fu_cfu = i_s2_fu[exu_pkg::FU_CFU];

    exu_pkg::alu_op_e     alu_op;
    exu_pkg::cfu_fields_t cfu;
    assign alu_op = i_s2_uop.alu;
    assign cfu    = i_s2_uop.cfu;

    wire cfu_cond = fu_cfu && cfu.kind == exu_pkg::CFU_COND;
    wire cfu_jalr = fu_cfu && cfu.kind == exu_pkg::CFU_JALR;
    wire cnd_uns  = cfu.cond == exu_pkg::CND_BLTU || cfu.cond == exu_pkg::CND_BGEU;

    logic            alu_lt, alu_eq;
    logic [XLEN-1:0] alu_result, alu_add_result;
    logic            mul_ready;
    logic [XLEN-1:0] mul_result;
    logic            taken;

    exu_alu #(.XLEN(XLEN)) alu_i (
        .i_op_add       (fu_alu && alu_op == exu_pkg::ALU_ADD),
        .i_op_sub       (fu_alu && alu_op == exu_pkg::ALU_SUB),
        .i_op_xor       (fu_alu && alu_op == exu_pkg::ALU_XOR),
        .i_op_or        (fu_alu && alu_op == exu_pkg::ALU_OR),
        .i_op_and       (fu_alu && alu_op == exu_pkg::ALU_AND),
        .i_op_shf       (fu_alu && alu_op inside {exu_pkg::ALU_SLL, exu_pkg::ALU_SRL,
                                                  exu_pkg::ALU_SRA}),
        .i_op_shf_left  (fu_alu && alu_op == exu_pkg::ALU_SLL),
        .i_op_shf_arith (fu_alu && alu_op == exu_pkg::ALU_SRA),
        .i_op_cmp       (fu_alu && alu_op inside {exu_pkg::ALU_SLT, exu_pkg::ALU_SLTU}),
        .i_op_unsigned  (fu_alu && alu_op == exu_pkg::ALU_SLTU || cfu_cond && cnd_uns),
        .i_lhs          (i_s2_opr_a),
        .i_rhs          (i_s2_opr_b),
        .o_result       (alu_result),
        .o_add_result   (alu_add_result),       // Also the jalr target
        .o_lt           (alu_lt),
        .o_eq           (alu_eq)
    );

    exu_muldiv #(.XLEN(XLEN)) muldiv_i (
        .g_clk      (g_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_valid    (i_s2_valid && fu_mul),
        .i_high     (i_s2_uop == exu_pkg::MUL_MULHU),
        .i_progress (o_p_valid),                // Op leaves execute
        .i_lhs      (i_s2_opr_a),
        .i_rhs      (i_s2_opr_b),
        .o_ready    (mul_ready),
        .o_result   (mul_result)
    );

    // ----------------------------------------
    // Branch resolve and result
    // ----------------------------------------
    always_comb begin
        case (cfu.cond)
            exu_pkg::CND_BEQ:                   taken = alu_eq;
            exu_pkg::CND_BNE:                   taken = !alu_eq;
            exu_pkg::CND_BLT, exu_pkg::CND_BLTU: taken = alu_lt;
            default:                            taken = !alu_lt;    // BGE, BGEU
        endcase
    end

    always_comb begin
        if (fu_cfu) begin
            o_p_kind = (cfu_cond && !taken) ? exu_pkg::RES_NONE : exu_pkg::RES_REDIRECT;
        end else if (i_s2_rd == '0) begin
            o_p_kind = exu_pkg::RES_NONE;       // x0 is never written
        end else begin
            o_p_kind = exu_pkg::RES_WRITE;
        end
    end

    assign o_p_value = fu_mul   ? mul_result :
                       cfu_jalr ? {alu_add_result[XLEN-1:1], 1'b0} :
                       fu_cfu   ? i_s2_opr_c : alu_result;
    assign o_p_rd    = i_s2_rd;

    // Multiply holds dispatch until its product is ready
    assign o_s2_busy = i_p_busy || i_s2_valid && fu_mul && !mul_ready;
    assign o_p_valid = i_s2_valid && !o_s2_busy;

endmodule

// File: source/pipe_register.sv
// ----------------------------------------
// Pipeline register
// One entry, valid/busy handshake, flush
// ----------------------------------------
module pipe_register #(
    parameter int WIDTH = 39
) (
    input  logic             g_clk,
    input  logic             i_rst_n,
    input  logic             i_flush,           // Drop held entry
    input  logic             i_valid,
    output logic             o_busy,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_valid,
    input  logic             i_busy,            // Downstream stall
    output logic [WIDTH-1:0] o_data
);

    logic full;

    // Empty or draining this edge means free
    assign o_busy  = full && i_busy;
    assign o_valid = full;

    always_ff @(posedge g_clk) begin
        if (!i_rst_n || i_flush) begin
            full <= 1'b0;
        end else if (!o_busy) begin
            full <= i_valid;                    // Refill on same edge
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_valid && !o_busy) begin
            o_data <= i_data;
        end
    end

endmodule

// File: source/exu_writeback.sv
// ----------------------------------------
// Writeback stage
// Turns results into register writes or
// fetch redirects, one cycle pulses
// ----------------------------------------
module exu_writeback #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                                         g_clk,
    input  logic                                         i_rst_n,
    input  logic                                         i_valid,
    output logic                                         o_busy,
    input  logic [exu_pkg::RD_W+exu_pkg::KIND_W+XLEN-1:0] i_data,
    input  logic                                         i_hold,    // External stall
    output logic                                         o_rf_we,
    output logic [exu_pkg::RD_W-1:0]                     o_rf_rd,
    output logic [XLEN-1:0]                              o_rf_wdata,
    output logic                                         o_redirect_valid,
    output logic [XLEN-1:0]                              o_redirect_pc
);

    exu_pkg::res_kind_e kind;
    logic [XLEN-1:0]    value;                  // Write data or target

    assign kind   = exu_pkg::res_kind_e'(i_data[XLEN +: exu_pkg::KIND_W]);
    assign o_busy = i_hold;

    wire accept = i_valid && !i_hold;

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            o_rf_we          <= 1'b0;
            o_redirect_valid <= 1'b0;
        end else begin
            o_rf_we          <= accept && kind == exu_pkg::RES_WRITE;
            o_redirect_valid <= accept && kind == exu_pkg::RES_REDIRECT;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_rf_rd <= i_data[XLEN+exu_pkg::KIND_W +: exu_pkg::RD_W];
            value   <= i_data[XLEN-1:0];
        end
    end

    assign o_rf_wdata    = value;
    assign o_redirect_pc = value;

endmodule

// File: source/exu_top.sv
// ----------------------------------------
// Execute subsystem top
// Execute, pipeline register, writeback
// ----------------------------------------
module exu_top #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                     g_clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_s2_valid,
    output logic                     o_s2_busy,
    input  logic [exu_pkg::RD_W-1:0] i_s2_rd,
    input  logic [exu_pkg::FU_W-1:0] i_s2_fu,
    input  exu_pkg::uop_u            i_s2_uop,
    input  logic [XLEN-1:0]          i_s2_opr_a,
    input  logic [XLEN-1:0]          i_s2_opr_b,
    input  logic [XLEN-1:0]          i_s2_opr_c,
    input  logic                     i_wb_hold,         // Writeback stall
    output logic                     o_rf_we,
    output logic [exu_pkg::RD_W-1:0] o_rf_rd,
    output logic [XLEN-1:0]          o_rf_wdata,
    output logic                     o_redirect_valid,
    output logic [XLEN-1:0]          o_redirect_pc
);

    localparam int P_W = exu_pkg::RD_W + exu_pkg::KIND_W + XLEN;  // {rd, kind, value}

    logic                     p_valid, p_busy;
    logic [exu_pkg::RD_W-1:0] p_rd;
    exu_pkg::res_kind_e       p_kind;
    logic [XLEN-1:0]          p_value;
    logic [P_W-1:0]           s3_data;
    logic                     s3_valid, s3_busy;

    exu_execute #(.XLEN(XLEN)) execute_i (
        .g_clk      (g_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_s2_valid (i_s2_valid),
        .o_s2_busy  (o_s2_busy),
        .i_s2_rd    (i_s2_rd),
        .i_s2_fu    (i_s2_fu),
        .i_s2_uop   (i_s2_uop),
        .i_s2_opr_a (i_s2_opr_a),
        .i_s2_opr_b (i_s2_opr_b),
        .i_s2_opr_c (i_s2_opr_c),
        .o_p_valid  (p_valid),
        .i_p_busy   (p_busy),
        .o_p_rd     (p_rd),
        .o_p_kind   (p_kind),
        .o_p_value  (p_value)
    );

    pipe_register #(.WIDTH(P_W)) pipe_i (
        .g_clk   (g_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_valid (p_valid),
        .o_busy  (p_busy),
        .i_data  ({p_rd, p_kind, p_value}),
        .o_valid (s3_valid),
        .i_busy  (s3_busy),
        .o_data  (s3_data)
    );

    exu_writeback #(.XLEN(XLEN)) writeback_i (
        .g_clk            (g_clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (s3_valid),
        .o_busy           (s3_busy),
        .i_data           (s3_data),
        .i_hold           (i_wb_hold),
        .o_rf_we          (o_rf_we),
        .o_rf_rd          (o_rf_rd),
        .o_rf_wdata       (o_rf_wdata),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

endmodule

// File: verification/tb_exu_top.sv
// ----------------------------------------
// Execute subsystem testbench
// Table-driven ops, reference model, random
// writeback hold, flush and scoreboard
// ----------------------------------------
module tb_exu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN  = exu_pkg::XLEN_DEF;
    localparam int N_MAX = 128;
    localparam int TMO   = 100;                 // Cycles per wait

    logic g_clk = 1'b0;
    logic i_rst_n, i_flush, i_s2_valid, i_wb_hold, o_s2_busy, o_rf_we, o_redirect_valid;
    logic [exu_pkg::RD_W-1:0] i_s2_rd, o_rf_rd;
    logic [exu_pkg::FU_W-1:0] i_s2_fu;
    exu_pkg::uop_u            i_s2_uop;
    logic [XLEN-1:0]          i_s2_opr_a, i_s2_opr_b, i_s2_opr_c, o_rf_wdata, o_redirect_pc;

    // Stimulus table with expected results
    logic [2:0]         t_fu [N_MAX];
    logic [4:0]         t_uop [N_MAX], t_rd [N_MAX];
    logic [XLEN-1:0]    t_a [N_MAX], t_b [N_MAX], t_c [N_MAX], t_val [N_MAX];
    exu_pkg::res_kind_e t_kind [N_MAX];
    bit                 t_hold [N_MAX];

    // Pending results, oldest first
    exu_pkg::res_kind_e q_kind [$];
    logic [4:0]         q_rd [$];
    logic [XLEN-1:0]    q_val [$];
    int                 q_cyc [$];
    bit                 q_lat [$];

    int          n_rows = 0, errors = 0, checks = 0, err_mark = 0, cyc = 0;
    int          e1, e2, e3, e4;
    logic [31:0] seed = 32'd76;
    bit          hold_en = 1'b0;
    logic [2:0]  conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    always #2 g_clk = ~g_clk;                   // 4 ns period

    exu_top #(.XLEN(XLEN)) exu_top_i (.*);

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic ref_model(input logic [2:0] fu, input logic [4:0] uop,
                             input logic [XLEN-1:0] a, b, c, input logic [4:0] rd,
                             output exu_pkg::res_kind_e kind, output logic [XLEN-1:0] val);
        logic [2*XLEN-1:0] prod;
        logic              tk;
        kind = exu_pkg::RES_WRITE;
        val  = '0;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        if (fu[exu_pkg::FU_ALU]) begin
            case (uop)
                5'd0: val = a + b;
                5'd1: val = a - b;
                5'd2: val = a ^ b;
                5'd3: val = a | b;
                5'd4: val = a & b;
                5'd5: val = a << b[4:0];
                5'd6: val = a >> b[4:0];
                5'd7: val = $signed(a) >>> b[4:0];
                5'd8: val = XLEN'($signed(a) < $signed(b));
                default: val = XLEN'(a < b);
            endcase
        end else if (fu[exu_pkg::FU_MUL]) begin
            val = uop[0] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end else begin
            case (uop[2:0])
                3'd0: tk = a == b;
                3'd1: tk = a != b;
                3'd4: tk = $signed(a) < $signed(b);
                3'd5: tk = $signed(a) >= $signed(b);
                3'd6: tk = a < b;
                default: tk = a >= b;
            endcase
            kind = exu_pkg::RES_REDIRECT;
            val  = (uop[4:3] == 2'd2) ? ((a + b) & ~XLEN'(1)) : c;
            if (uop[4:3] == 2'd0 && !tk) kind = exu_pkg::RES_NONE;
        end
        if (!fu[exu_pkg::FU_CFU] && rd == '0) kind = exu_pkg::RES_NONE;    // x0 never written
    endtask

    task automatic add_row(input logic [2:0] fu, input logic [4:0] uop,
                           input logic [XLEN-1:0] a, b, c, input logic [4:0] rd, input bit hold);
        t_fu[n_rows]   = fu;
        t_uop[n_rows]  = uop;
        t_a[n_rows]    = a;
        t_b[n_rows]    = b;
        t_c[n_rows]    = c;
        t_rd[n_rows]   = rd;
        t_hold[n_rows] = hold;
        ref_model(fu, uop, a, b, c, rd, t_kind[n_rows], t_val[n_rows]);
        n_rows++;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Testbench failed");
        $finish;
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_write(input logic [exu_pkg::RD_W-1:0] exp_rd, input logic [XLEN-1:0] exp_data);
        checks++;
        if (o_rf_rd !== exp_rd || o_rf_wdata !== exp_data) begin
            errors++;
            $display("Mismatch at %0t: write rd %0d data %h, expected rd %0d data %h",
                     $time, o_rf_rd, o_rf_wdata, exp_rd, exp_data);
        end
    endtask

    task automatic check_redirect(input logic [XLEN-1:0] exp_pc);
        checks++;
        if (o_redirect_pc !== exp_pc) begin
            errors++;
            $display("Mismatch at %0t: redirect pc %h, expected %h", $time, o_redirect_pc, exp_pc);
        end
    endtask

    always @(posedge g_clk) begin
        cyc <= cyc + 1;
        i_wb_hold <= hold_en ? 1'(lcg() >> 31) : 1'b0;          // Random back-pressure
    end

    // Scoreboard checks outputs at the falling edge
    always @(negedge g_clk) begin
        if (i_rst_n && (o_rf_we || o_redirect_valid)) begin
            if (q_kind.size() == 0) begin
                errors++;
                $display("Output at %0t with no result pending", $time);
            end else begin
                if (o_rf_we && q_kind[0] != exu_pkg::RES_WRITE ||
                    o_redirect_valid && q_kind[0] != exu_pkg::RES_REDIRECT) begin
                    errors++;
                    $display("Mismatch at %0t: wrong output kind, expected %0d", $time, q_kind[0]);
                end else if (o_rf_we) begin
                    check_write(q_rd[0], q_val[0]);
                end else begin
                    check_redirect(q_val[0]);
                end
                if (q_lat[0] && cyc - q_cyc[0] != 2) begin
                    errors++;
                    $display("Result arrived %0d cycles after acceptance instead of 2", cyc - q_cyc[0]);
                end
                void'(q_kind.pop_front());
                void'(q_rd.pop_front());
                void'(q_val.pop_front());
                void'(q_cyc.pop_front());
                void'(q_lat.pop_front());
            end
        end
    end

    // Issue rows back to back and hold valid while busy
    task automatic run_rows(input int first, input int last);
        int n;
        bit is_mul;
        for (int i = first; i < last; i++) begin
            @(posedge g_clk);
            i_s2_valid <= 1'b1;
            i_s2_fu    <= t_fu[i];
            i_s2_uop   <= exu_pkg::uop_u'(t_uop[i]);
            i_s2_opr_a <= t_a[i];
            i_s2_opr_b <= t_b[i];
            i_s2_opr_c <= t_c[i];
            i_s2_rd    <= t_rd[i];
            hold_en    <= t_hold[i];
            is_mul = t_fu[i][exu_pkg::FU_MUL];
            n = 0;
            @(negedge g_clk);
            while (o_s2_busy) begin
                n++;
                if (n > TMO) timeout_fail("o_s2_busy low");
                @(negedge g_clk);
            end
            if (is_mul && n < 32) begin
                errors++;
                $display("Multiply accepted after only %0d busy cycles", n);
            end
            if (t_kind[i] != exu_pkg::RES_NONE) begin
                q_kind.push_back(t_kind[i]);
                q_rd.push_back(t_rd[i]);
                q_val.push_back(t_val[i]);
                q_cyc.push_back(cyc);
                q_lat.push_back(!t_hold[i] && !is_mul);
            end
        end
        @(posedge g_clk);
        i_s2_valid <= 1'b0;
        hold_en    <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (q_kind.size() != 0) begin
            n++;
            if (n > TMO) timeout_fail("pending results");
            @(negedge g_clk);
        end
        repeat (4) @(negedge g_clk);            // Catch stray pulses
    endtask

    task automatic report(input string name);
        $display("%s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_flush = 1'b0;
        i_s2_valid = 1'b0;
        i_wb_hold = 1'b0;
        i_s2_rd = '0;
        i_s2_fu = '0;
        i_s2_uop = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        for (int op = 0; op < 10; op++) begin   // ALU edges then random
            add_row(3'b001, 5'(op), 32'h8000_0000, 32'h0000_001f, '0, 5'(op + 1), 1'b0);
            add_row(3'b001, 5'(op), 32'hffff_ffff, 32'h0000_0001, '0, 5'(op + 1), 1'b0);
            add_row(3'b001, 5'(op), lcg(), lcg(), '0, 5'(op + 11), 1'b0);
            add_row(3'b001, 5'(op), lcg(), lcg(), '0, 5'(op + 21), 1'b0);
        end
        e1 = n_rows;
        for (int k = 0; k < 6; k++) begin
            add_row(3'b100, {2'd0, conds[k]}, 32'd5, 32'd5, lcg() & ~32'd3, '0, 1'b0);
            add_row(3'b100, {2'd0, conds[k]}, 32'hffff_ffff, 32'd1, lcg() & ~32'd3, '0, 1'b0);
            add_row(3'b100, {2'd0, conds[k]}, 32'd1, 32'hffff_ffff, lcg() & ~32'd3, '0, 1'b0);
        end
        add_row(3'b100, {2'd1, 3'd0}, '0, '0, 32'h0000_2468, '0, 1'b0);
        add_row(3'b100, {2'd2, 3'd0}, 32'h0000_1001, 32'h0000_000a, '0, '0, 1'b0);
        e2 = n_rows;
        for (int k = 0; k < 6; k++) begin
            add_row(3'b010, 5'(k % 2), lcg(), lcg(), '0, 5'(k + 10), 1'b0);
        end
        e3 = n_rows;
        for (int k = 0; k < 30; k++) begin      // Mixed burst under hold
            case ((lcg() >> 16) % 3)
                0: add_row(3'b001, 5'((lcg() >> 16) % 10), lcg(), lcg(), '0,
                           5'(lcg() >> 27), 1'b1);
                1: add_row(3'b010, 5'((lcg() >> 16) % 2), lcg(), lcg(), '0,
                           5'(lcg() >> 27), 1'b1);
                default: add_row(3'b100, {2'((lcg() >> 16) % 3), conds[(lcg() >> 16) % 6]},
                                 lcg() >> 30, lcg() >> 30, lcg() & ~32'd3, '0, 1'b1);
            endcase
        end
        e4 = n_rows;
        add_row(3'b010, 5'd1, lcg(), lcg(), '0, 5'd6, 1'b0);    // Fresh multiply after flush
        add_row(3'b001, 5'd0, 32'd7, 32'd9, '0, 5'd3, 1'b0);
        add_row(3'b001, 5'd0, 32'd7, 32'd9, '0, 5'd0, 1'b0);    // x0 gives no write

        repeat (5) @(posedge g_clk);
        i_rst_n <= 1'b1;
        run_rows(0, e1);
        drain();
        report("Test 1 ALU ops");
        run_rows(e1, e2);
        drain();
        report("Test 2 branches and jumps");
        run_rows(e2, e3);
        drain();
        report("Test 3 multiply");
        run_rows(e3, e4);
        drain();
        report("Test 4 burst with hold");

        @(posedge g_clk);                       // Multiply then flush midway
        i_s2_valid <= 1'b1;
        i_s2_fu    <= 3'b010;
        i_s2_uop   <= exu_pkg::uop_u'(5'd0);
        i_s2_rd    <= 5'd5;
        repeat (10) @(negedge g_clk);
        if (!o_s2_busy) begin
            errors++;
            $display("o_s2_busy dropped during a multiply");
        end
        @(posedge g_clk);
        i_flush <= 1'b1;                        // Flush while the multiply is still valid
        @(posedge g_clk);
        i_flush    <= 1'b0;
        i_s2_valid <= 1'b0;
        run_rows(e4, n_rows);
        drain();
        report("Test 5 flush and x0");

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
common/exu_pkg.sv
execute/exu_alu.sv
execute/exu_muldiv.sv
execute/exu_execute.sv
source/pipe_register.sv
source/exu_writeback.sv
source/exu_top.sv
verification/tb_exu_top.sv

// File: Bender.yml
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - execute/exu_alu.sv
  - execute/exu_muldiv.sv
  - execute/exu_execute.sv
  - source/pipe_register.sv
  - source/exu_writeback.sv
  - source/exu_top.sv
  - target: test
    files:
      - verification/tb_exu_top.sv
